//--- core_mem_region.f
+incdir+verilog
+incdir+verif
verilog/core_mem_pkg.sv
verilog/sp_ram.sv
verilog/ram_port_mux.sv
verilog/lsu_demux.sv
verilog/core_mem_region.sv
verif/tb_core_mem_region.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_core_mem_region
RTL_TOP   ?= core_mem_region
FILELIST  ?= core_mem_region.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

RTL_SRCS ?= verilog/core_mem_pkg.sv verilog/sp_ram.sv verilog/ram_port_mux.sv \
            verilog/lsu_demux.sv verilog/core_mem_region.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
	  echo "Run failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "Simulation PASSED" $(LOG) || (echo "No result in $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall +incdir+verilog --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/tb_mem_model.svh
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

// Shadow copies of both RAMs, indexed by word address
logic [`CMR_DATA_W-1:0] instr_model [2**`CMR_INSTR_AW];
logic [`CMR_DATA_W-1:0] data_model [2**`CMR_DATA_AW];

// Sparse external memory, keyed by word-aligned byte address
logic [`CMR_DATA_W-1:0] ext_model [logic [`CMR_ADDR_W-1:0]];

// Only the enabled bytes take the new value
function automatic logic [`CMR_DATA_W-1:0] merge_be(input logic [`CMR_DATA_W-1:0] old_word,
                                                    input logic [`CMR_DATA_W-1:0] new_word,
                                                    input logic [`CMR_BE_W-1:0] be);
  logic [`CMR_DATA_W-1:0] w;
  w = old_word;
  for (int i = 0; i < `CMR_BE_W; i++)
  begin
    if (be[i])
    begin
      w[8*i +: 8] = new_word[8*i +: 8];
    end
  end
  return w;
endfunction

// Region tag in the top address bits selects the local data RAM
function automatic logic is_local_addr(input logic [`CMR_ADDR_W-1:0] addr);
  lsu_addr_u a;
  a.raw = addr;
  return a.fields.region == `CMR_LOCAL_REGION;
endfunction

// Initial RAM contents
function automatic logic [`CMR_DATA_W-1:0] fill_word(input logic instr_side,
                                                     input int unsigned idx);
  return {instr_side, idx[14:0], ~idx[15:0]} ^ 32'h3c5a_96e1;
endfunction

// Unwritten external words follow a pattern over the whole address
function automatic logic [`CMR_DATA_W-1:0] ext_word_at(input logic [`CMR_ADDR_W-1:0] addr);
  logic [`CMR_ADDR_W-1:0] key;
  key = {addr[`CMR_ADDR_W-1:2], 2'b00};
  if (ext_model.exists(key))
  begin
    return ext_model[key];
  end
  return {key[15:0], key[31:16]} ^ 32'h9e37_79b9;
endfunction

function automatic void ext_write(input logic [`CMR_ADDR_W-1:0] addr,
                                  input logic [`CMR_BE_W-1:0] be,
                                  input logic [`CMR_DATA_W-1:0] wdata);
  logic [`CMR_ADDR_W-1:0] key;
  key = {addr[`CMR_ADDR_W-1:2], 2'b00};
  ext_model[key] = merge_be(ext_word_at(addr), wdata, be);
endfunction

`endif

//--- verif/tb_core_mem_region.sv
`timescale 1ns/1ns

`include "core_mem_defs.svh"

module tb_core_mem_region;

  import core_mem_pkg::*;

  localparam int unsigned IWORDS = 2 ** `CMR_INSTR_AW;
  localparam int unsigned DWORDS = 2 ** `CMR_DATA_AW;
  localparam int TIMEOUT = 64;

  logic                   clk;
  logic                   rst_n;
  mem_req_t               fetch_req_i;
  logic                   fetch_gnt_o;
  mem_rsp_t               fetch_rsp_o;
  mem_req_t               lsu_req_i;
  logic                   lsu_gnt_o;
  mem_rsp_t               lsu_rsp_o;
  mem_req_t               ext_req_o;
  logic                   ext_gnt_i;
  mem_rsp_t               ext_rsp_i;
  mem_req_t               iload_req_i;
  logic [`CMR_DATA_W-1:0] iload_rdata_o;
  mem_req_t               dload_req_i;
  logic [`CMR_DATA_W-1:0] dload_rdata_o;

  integer                 seed = 64;
  int                     errors = 0;
  int                     timeouts = 0;
  int                     checks = 0;
  int                     ext_delay = 0;
  logic [`CMR_DATA_W-1:0] ext_rdata;

  `include "tb_mem_model.svh"

  core_mem_region core_mem_region_i
  (
    .clk           ( clk           ),
    .rst_n         ( rst_n         ),
    .fetch_req_i   ( fetch_req_i   ),
    .fetch_gnt_o   ( fetch_gnt_o   ),
    .fetch_rsp_o   ( fetch_rsp_o   ),
    .lsu_req_i     ( lsu_req_i     ),
    .lsu_gnt_o     ( lsu_gnt_o     ),
    .lsu_rsp_o     ( lsu_rsp_o     ),
    .ext_req_o     ( ext_req_o     ),
    .ext_gnt_i     ( ext_gnt_i     ),
    .ext_rsp_i     ( ext_rsp_i     ),
    .iload_req_i   ( iload_req_i   ),
    .iload_rdata_o ( iload_rdata_o ),
    .dload_req_i   ( dload_req_i   ),
    .dload_rdata_o ( dload_rdata_o )
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check_eq(input logic [`CMR_DATA_W-1:0] actual,
                          input logic [`CMR_DATA_W-1:0] expected, input string what);
    checks++;
    assert (actual === expected)
    else
    begin
      errors++;
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic check_bit(input logic actual, input logic expected, input string what);
    checks++;
    assert (actual === expected)
    else
    begin
      errors++;
      $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
    end
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("Timeout at %0t ns: %s did not happen within %0d cycles", $time, what, TIMEOUT);
  endtask

  function automatic mem_req_t make_req(input logic we, input logic [`CMR_ADDR_W-1:0] addr);
    mem_req_t r;
    r.req   = 1'b1;
    r.we    = we;
    r.be    = 4'($random(seed));
    r.addr  = addr;
    r.wdata = $random(seed);
    return r;
  endfunction

  // Random word-aligned address inside or outside the local region
  function automatic logic [`CMR_ADDR_W-1:0] make_addr(input logic local_side);
    lsu_addr_u a;
    a.raw      = $random(seed);
    a.raw[1:0] = 2'b00;
    if (local_side)
    begin
      a.fields.region = `CMR_LOCAL_REGION;
    end
    while (!local_side && a.fields.region == `CMR_LOCAL_REGION)
    begin
      a.fields.region = 12'($random(seed));
    end
    return a.raw;
  endfunction

  task automatic preload_write(input logic instr_side, input int unsigned idx,
                               input logic [`CMR_BE_W-1:0] be, input logic [`CMR_DATA_W-1:0] d);
    mem_req_t r;
    r       = make_req(1'b1, 32'(idx) << 2);
    r.be    = be;
    r.wdata = d;
    @(negedge clk);
    if (instr_side)
    begin
      iload_req_i     = r;
      instr_model[idx] = merge_be(instr_model[idx], d, be);
    end
    else
    begin
      dload_req_i     = r;
      data_model[idx] = merge_be(data_model[idx], d, be);
    end
    @(negedge clk);
    iload_req_i = '0;
    dload_req_i = '0;
  endtask

  task automatic preload_read(input logic instr_side, input int unsigned idx);
    mem_req_t r;
    r = make_req(1'b0, 32'(idx) << 2);
    @(negedge clk);
    if (instr_side)
    begin
      iload_req_i = r;
    end
    else
    begin
      dload_req_i = r;
    end
    @(negedge clk);
    iload_req_i = '0;
    dload_req_i = '0;
    #3;
    if (instr_side)
    begin
      check_eq(iload_rdata_o, instr_model[idx], "instruction preload rdata");
    end
    else
    begin
      check_eq(dload_rdata_o, data_model[idx], "data preload rdata");
    end
  endtask

  // Preload idle, so the grant must come in the request cycle
  task automatic fetch_op(input int unsigned idx, input logic we);
    @(negedge clk);
    fetch_req_i = make_req(we, 32'(idx) << 2);
    #3;
    check_bit(fetch_gnt_o, 1'b1, "fetch grant with idle preload");
    @(negedge clk);
    fetch_req_i = '0;
    #3;
    check_bit(fetch_rsp_o.rvalid, 1'b1, "fetch rvalid");
    check_eq(fetch_rsp_o.rdata, instr_model[idx], "fetch rdata");
    // A dropped fetch write leaves the word as modeled
    if (we)
    begin
      preload_read(1'b1, idx);
    end
  endtask

  task automatic check_route(input mem_req_t r, input logic loc);
    if (loc)
    begin
      check_bit(ext_req_o.req, 1'b0, "ext req for local access");
    end
    else
    begin
      check_bit(ext_req_o.req, 1'b1, "ext req");
      check_bit(ext_req_o.we, r.we, "ext we");
      check_eq(ext_req_o.addr, r.addr, "ext addr");
      check_eq(32'(ext_req_o.be), 32'(r.be), "ext be");
      check_eq(ext_req_o.wdata, r.wdata, "ext wdata");
    end
  endtask

  task automatic lsu_op(input logic [`CMR_ADDR_W-1:0] addr, input logic we);
    mem_req_t               r;
    logic                   loc;
    logic [`CMR_DATA_W-1:0] expected;
    int unsigned            idx;
    int                     n;
    loc = is_local_addr(addr);
    idx = int'(addr[`CMR_DATA_AW+1:2]);
    r   = make_req(we, addr);
    @(negedge clk);
    lsu_req_i = r;
    #3;
    n = 0;
    while (!lsu_gnt_o && n < TIMEOUT)
    begin
      check_route(r, loc);
      @(negedge clk);
      #3;
      n++;
    end
    if (!lsu_gnt_o)
    begin
      report_timeout("load/store grant");
      lsu_req_i = '0;
      return;
    end
    check_route(r, loc);
    if (loc)
    begin
      check_eq(32'(n), 32'd0, "local grant delay");
      expected = data_model[idx];
      if (we)
      begin
        data_model[idx] = merge_be(data_model[idx], r.wdata, r.be);
      end
    end
    else
    begin
      expected = ext_word_at(addr);
      if (we)
      begin
        ext_write(addr, r.be, r.wdata);
      end
    end
    @(negedge clk);
    lsu_req_i = '0;
    #3;
    n = 0;
    while (!loc && !ext_rsp_i.rvalid && n < TIMEOUT)
    begin
      check_bit(lsu_rsp_o.rvalid, 1'b0, "load/store rvalid before ext response");
      @(negedge clk);
      #3;
      n++;
    end
    if (!loc && !ext_rsp_i.rvalid)
    begin
      report_timeout("external response");
      return;
    end
    check_bit(lsu_rsp_o.rvalid, 1'b1, "load/store rvalid");
    if (!we)
    begin
      check_eq(lsu_rsp_o.rdata, expected, "load/store rdata");
    end
  endtask

  // Preload write and core read to the same word in one cycle
  task automatic contend(input logic instr_side);
    mem_req_t               pre;
    mem_req_t               core;
    int unsigned            idx;
    logic [`CMR_DATA_W-1:0] expected;
    core = make_req(1'b0, make_addr(1'b1));
    if (instr_side)
    begin
      idx = int'(core.addr[`CMR_INSTR_AW+1:2]);
    end
    else
    begin
      idx = int'(core.addr[`CMR_DATA_AW+1:2]);
    end
    pre  = make_req(1'b1, 32'(idx) << 2);
    @(negedge clk);
    if (instr_side)
    begin
      iload_req_i      = pre;
      fetch_req_i      = core;
      instr_model[idx] = merge_be(instr_model[idx], pre.wdata, pre.be);
      expected         = instr_model[idx];
    end
    else
    begin
      dload_req_i     = pre;
      lsu_req_i       = core;
      data_model[idx] = merge_be(data_model[idx], pre.wdata, pre.be);
      expected        = data_model[idx];
    end
    #3;
    check_bit(instr_side ? fetch_gnt_o : lsu_gnt_o, 1'b0, "core grant under preload");
    @(negedge clk);
    iload_req_i = '0;
    dload_req_i = '0;
    #3;
    check_bit(instr_side ? fetch_gnt_o : lsu_gnt_o, 1'b1, "held core grant");
    @(negedge clk);
    fetch_req_i = '0;
    lsu_req_i   = '0;
    #3;
    check_bit(instr_side ? fetch_rsp_o.rvalid : lsu_rsp_o.rvalid, 1'b1, "held core rvalid");
    check_eq(instr_side ? fetch_rsp_o.rdata : lsu_rsp_o.rdata, expected, "held core rdata");
  endtask

  // External bus slave with random grant and 1 to 4 cycles of latency
  initial
  begin
    ext_gnt_i = 1'b0;
    ext_rsp_i = '0;
    forever
    begin
      @(negedge clk);
      ext_rsp_i = '0;
      if (ext_delay > 0)
      begin
        ext_delay--;
        if (ext_delay == 0)
        begin
          ext_rsp_i.rvalid = 1'b1;
          ext_rsp_i.rdata  = ext_rdata;
        end
      end
      ext_gnt_i = (ext_delay == 0 && rst_n) ? 1'($random(seed)) : 1'b0;
      #3;
      if (ext_req_o.req && ext_gnt_i)
      begin
        ext_delay = 1 + int'({$random(seed)} % 4);
        ext_rdata = ext_word_at(ext_req_o.addr);
      end
    end
  end

  initial
  begin
    for (int c = 0; c < 200000; c++)
    begin
      @(posedge clk);
    end
    $display("Timeout: the test sequence did not finish in time");
    $display("Simulation FAILED");
    $finish;
  end

  initial
  begin
    rst_n       = 1'b0;
    fetch_req_i = '0;
    lsu_req_i   = '0;
    iload_req_i = '0;
    dload_req_i = '0;
    for (int c = 0; c < 18; c++)
    begin
      @(negedge clk);
      // Reset released on pass 16
      if (c == 16)
      begin
        rst_n = 1'b1;
      end
      // Last pass sees the first cycle out of reset
      #3;
      check_bit(fetch_rsp_o.rvalid, 1'b0, "fetch rvalid around reset");
      check_bit(lsu_rsp_o.rvalid, 1'b0, "load/store rvalid around reset");
    end

    for (int unsigned i = 0; i < IWORDS; i++)
    begin
      preload_write(1'b1, i, 4'hf, fill_word(1'b1, i));
    end
    for (int unsigned i = 0; i < DWORDS; i++)
    begin
      preload_write(1'b0, i, 4'hf, fill_word(1'b0, i));
    end

    repeat (200) preload_write(1'($random(seed)), {$random(seed)} % DWORDS,
                               4'($random(seed)), $random(seed));
    repeat (100) preload_read(1'($random(seed)), {$random(seed)} % DWORDS);
    repeat (150) fetch_op({$random(seed)} % IWORDS, 1'($random(seed)));
    repeat (200) lsu_op(make_addr(1'b1), 1'($random(seed)));
    repeat (150) lsu_op(make_addr(1'b0), 1'($random(seed)));
    repeat (100) preload_read(1'b0, {$random(seed)} % DWORDS);
    repeat (20) contend(1'b1);
    repeat (20) contend(1'b0);

    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0)
    begin
      $display("Simulation PASSED");
    end
    else
    begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- verilog/core_mem_region.sv
`timescale 1ns/1ns

`include "core_mem_defs.svh"

module core_mem_region
(
  input  logic                     clk,
  input  logic                     rst_n,

  // Instruction fetch port
  input  core_mem_pkg::mem_req_t   fetch_req_i,
  output logic                     fetch_gnt_o,
  output core_mem_pkg::mem_rsp_t   fetch_rsp_o,

  // Load/store port
  input  core_mem_pkg::mem_req_t   lsu_req_i,
  output logic                     lsu_gnt_o,
  output core_mem_pkg::mem_rsp_t   lsu_rsp_o,

  // External bus master
  output core_mem_pkg::mem_req_t   ext_req_o,
  input  logic                     ext_gnt_i,
  input  core_mem_pkg::mem_rsp_t   ext_rsp_i,

  // Instruction RAM preload
  input  core_mem_pkg::mem_req_t   iload_req_i,
  output logic [`CMR_DATA_W-1:0]   iload_rdata_o,

  // Data RAM preload
  input  core_mem_pkg::mem_req_t   dload_req_i,
  output logic [`CMR_DATA_W-1:0]   dload_rdata_o
);

  import core_mem_pkg::*;

  // Demux to data RAM mux
  mem_req_t data_ram_req;
  logic     data_ram_gnt;
  mem_rsp_t data_ram_rsp;

  lsu_demux lsu_demux_i
  (
    .clk       ( clk          ),
    .rst_n     ( rst_n        ),

    .lsu_req_i ( lsu_req_i    ),
    .lsu_gnt_o ( lsu_gnt_o    ),
    .lsu_rsp_o ( lsu_rsp_o    ),

    .ram_req_o ( data_ram_req ),
    .ram_gnt_i ( data_ram_gnt ),
    .ram_rsp_i ( data_ram_rsp ),

    .ext_req_o ( ext_req_o    ),
    .ext_gnt_i ( ext_gnt_i    ),
    .ext_rsp_i ( ext_rsp_i    )
  );

  // Instruction memory, fetch cannot write
  ram_port_mux
  #(
    .ADDR_W        ( `CMR_INSTR_AW ),
    .CORE_WRITE_EN ( 1'b0          )
  )
  instr_ram_mux
  (
    .clk          ( clk           ),
    .rst_n        ( rst_n         ),

    .load_req_i   ( iload_req_i   ),
    .load_rdata_o ( iload_rdata_o ),

    .core_req_i   ( fetch_req_i   ),
    .core_gnt_o   ( fetch_gnt_o   ),
    .core_rsp_o   ( fetch_rsp_o   )
  );

  // Data memory behind the local region
  ram_port_mux
  #(
    .ADDR_W        ( `CMR_DATA_AW ),
    .CORE_WRITE_EN ( 1'b1         )
  )
  data_ram_mux
  (
    .clk          ( clk           ),
    .rst_n        ( rst_n         ),

    .load_req_i   ( dload_req_i   ),
    .load_rdata_o ( dload_rdata_o ),

    .core_req_i   ( data_ram_req  ),
    .core_gnt_o   ( data_ram_gnt  ),
    .core_rsp_o   ( data_ram_rsp  )
  );

endmodule

//--- verilog/lsu_demux.sv
`timescale 1ns/1ns

`include "core_mem_defs.svh"

module lsu_demux
(
  input  logic                     clk,
  input  logic                     rst_n,

  // Load/store port from the core
  input  core_mem_pkg::mem_req_t   lsu_req_i,
  output logic                     lsu_gnt_o,
  output core_mem_pkg::mem_rsp_t   lsu_rsp_o,

  // Local data RAM side
  output core_mem_pkg::mem_req_t   ram_req_o,
  input  logic                     ram_gnt_i,
  input  core_mem_pkg::mem_rsp_t   ram_rsp_i,

  // External bus side
  output core_mem_pkg::mem_req_t   ext_req_o,
  input  logic                     ext_gnt_i,
  input  core_mem_pkg::mem_rsp_t   ext_rsp_i
);

  import core_mem_pkg::*;

  lsu_addr_u addr_view;
  logic      is_local;
  resp_src_e src_q;
  resp_src_e src_d;

  // Region decode on the top address bits
  assign addr_view.raw = lsu_req_i.addr;
  assign is_local      = (addr_view.fields.region == `CMR_LOCAL_REGION);

  always_comb
  begin
    ram_req_o      = lsu_req_i;
    ram_req_o.addr = addr_view.raw;
    ram_req_o.req  = lsu_req_i.req & is_local;

    ext_req_o      = lsu_req_i;
    ext_req_o.addr = addr_view.raw;
    ext_req_o.req  = lsu_req_i.req & ~is_local;
  end

  // Grant and next response owner
  always_comb
  begin
    src_d     = src_q;
    lsu_gnt_o = 1'b0;

    if (lsu_req_i.req)
    begin
      if (is_local)
      begin
        src_d     = SRC_RAM;
        lsu_gnt_o = ram_gnt_i;
      end
      else
      begin
        src_d     = SRC_EXT;
        lsu_gnt_o = ext_gnt_i;
      end
    end
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      src_q <= SRC_RAM;
    end
    else
    begin
      src_q <= src_d;
    end
  end

  // Return path
  assign lsu_rsp_o = (src_q == SRC_EXT) ? ext_rsp_i : ram_rsp_i;

endmodule

//--- verilog/ram_port_mux.sv
`timescale 1ns/1ns

`include "core_mem_defs.svh"

module ram_port_mux
#(
  parameter int ADDR_W        = 10,
  parameter bit CORE_WRITE_EN = 1'b1
)
(
  input  logic                     clk,
  input  logic                     rst_n,

  // Preload port, never stalled
  input  core_mem_pkg::mem_req_t   load_req_i,
  output logic [`CMR_DATA_W-1:0]   load_rdata_o,

  // Core port
  input  core_mem_pkg::mem_req_t   core_req_i,
  output logic                     core_gnt_o,
  output core_mem_pkg::mem_rsp_t   core_rsp_o
);

  import core_mem_pkg::*;

  mem_req_t               sel_req;
  logic                   core_accept;
  logic                   load_owner_q;
  logic                   core_rvalid_q;
  logic [`CMR_DATA_W-1:0] ram_rdata;

  // Preload has priority, core only gets idle cycles
  assign core_gnt_o  = ~load_req_i.req;
  assign core_accept = core_req_i.req & core_gnt_o;

  always_comb
  begin
    if (load_req_i.req)
    begin
      sel_req = load_req_i;
    end
    else
    begin
      sel_req    = core_req_i;
      // Instruction side is read-only for the core
      sel_req.we = core_req_i.we & CORE_WRITE_EN;
    end
  end

  sp_ram
  #(
    .ADDR_W ( ADDR_W )
  )
  sp_ram_i
  (
    .clk     ( clk                        ),
    .en_i    ( sel_req.req                ),
    .we_i    ( sel_req.we                 ),
    .addr_i  ( sel_req.addr[ADDR_W+1:2]   ),
    .be_i    ( sel_req.be                 ),
    .wdata_i ( sel_req.wdata              ),
    .rdata_o ( ram_rdata                  )
  );

  // Remember who was served last cycle
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      load_owner_q  <= 1'b0;
      core_rvalid_q <= 1'b0;
    end
    else
    begin
      load_owner_q  <= load_req_i.req;
      core_rvalid_q <= core_accept;
    end
  end

  // Steer read data to its owner
  assign load_rdata_o      = load_owner_q ? ram_rdata : '0;
  assign core_rsp_o.rvalid = core_rvalid_q;
  assign core_rsp_o.rdata  = load_owner_q ? '0 : ram_rdata;

endmodule

//--- verilog/sp_ram.sv
`timescale 1ns/1ns

`include "core_mem_defs.svh"

module sp_ram
#(
  parameter int ADDR_W = 10
)
(
  input  logic                   clk,
  input  logic                   en_i,
  input  logic                   we_i,
  input  logic [ADDR_W-1:0]      addr_i,
  input  logic [`CMR_BE_W-1:0]   be_i,
  input  logic [`CMR_DATA_W-1:0] wdata_i,
  output logic [`CMR_DATA_W-1:0] rdata_o
);

  localparam int NUM_WORDS = 2 ** ADDR_W;

  logic [`CMR_DATA_W-1:0] mem [NUM_WORDS];

  // Byte-wise write, registered read
  always_ff @(posedge clk)
  begin
    if (en_i)
    begin
      if (we_i)
      begin
        for (int i = 0; i < `CMR_BE_W; i++)
        begin
          if (be_i[i])
          begin
            mem[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
          end
        end
      end
      else
      begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

//--- verilog/core_mem_pkg.sv
`include "core_mem_defs.svh"

package core_mem_pkg;

  // Request from any master toward a memory port
  typedef struct packed {
    logic                     req;
    logic                     we;
    logic [`CMR_BE_W-1:0]     be;
    logic [`CMR_ADDR_W-1:0]   addr;
    logic [`CMR_DATA_W-1:0]   wdata;
  } mem_req_t;

  // Response back to the master
  typedef struct packed {
    logic                     rvalid;
    logic [`CMR_DATA_W-1:0]   rdata;
  } mem_rsp_t;

  // One address word, flat or split into region tag and offset
  typedef union packed {
    logic [`CMR_ADDR_W-1:0] raw;
    struct packed {
      logic [`CMR_REGION_W-1:0]             region;
      logic [`CMR_ADDR_W-`CMR_REGION_W-1:0] offset;
    } fields;
  } lsu_addr_u;

  // Which side owns the pending load/store response
  typedef enum logic [0:0] {
    SRC_RAM = 1'b0,
    SRC_EXT = 1'b1
  } resp_src_e;

endpackage

//--- verilog/core_mem_defs.svh
`ifndef CORE_MEM_DEFS_SVH
`define CORE_MEM_DEFS_SVH

// Bus widths
`define CMR_DATA_W 32
`define CMR_BE_W 4
`define CMR_ADDR_W 32

// Region tag in the top address bits
`define CMR_REGION_W 12
`define CMR_LOCAL_REGION 12'h001

// RAM word-address widths
`define CMR_INSTR_AW 10
`define CMR_DATA_AW 10

`endif
